// ==== compile.f ====
src/cache_cfg_pkg.sv
src/cache_req_pkg.sv
src/array_if.sv
src/cache_set_array.sv
src/req_arbiter.sv
src/hit_resolve.sv
src/cache_ctrl_top.sv
verification/tb_clock_gen.sv
verification/cache_ctrl_tb.sv

// ==== Makefile ====
TOP := cache_ctrl_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f -o V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf obj_dir

// ==== verification/cache_ctrl_tb.sv ====
////////////////////
// Cache controller testbench
// Stimulus table, credit responder, watchdog
////////////////////
module cache_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned MissCredits = 2;
    localparam int unsigned CyclesPerRow = 40;

    typedef enum {K_LOAD, K_STORE, K_REFILL, K_PAUSE, K_STARVED, K_BOTH} kind_e;

    // addr is the core address, fill the refill address, wdata also carries refill data
    typedef struct {
        kind_e        kind;
        logic [15:0]  addr;
        logic [15:0]  fill;
        logic [63:0]  wdata;
        logic [7:0]   be;
        logic [3:0]   tid;
        bit           exp_hit;
        logic [63:0]  exp_rdata;
    } row_t;

    logic clk;
    logic rst_n;
    logic core_req_valid_i;
    logic core_req_ready_o;
    cache_req_pkg::op_e core_req_op_i;
    logic [15:0] core_req_addr_i;
    logic [63:0] core_req_wdata_i;
    logic [7:0]  core_req_be_i;
    logic [3:0]  core_req_tid_i;
    logic        core_rsp_valid_o;
    logic [63:0] core_rsp_rdata_o;
    logic [3:0]  core_rsp_tid_o;
    logic        core_rsp_hit_o;
    logic        refill_valid_i;
    logic        refill_ready_o;
    logic [12:0] refill_addr_i;
    logic [63:0] refill_data_i;
    logic        miss_req_valid_o;
    logic [12:0] miss_req_addr_o;
    logic        miss_credit_i;

    row_t rows[$];
    int   credit_due[$];
    int   cycles = 0;
    int   limit = 0;
    int   checks = 0;
    int   errors = 0;
    int   misses = 0;
    int   returned = 0;
    bit   hold_credits = 1'b0;

    tb_clock_gen clock0 (.clk_o (clk), .rst_no (rst_n));

    cache_ctrl_top #(.MissCredits (MissCredits)) dut0 (.clk_i (clk), .rst_ni (rst_n), .*);

    task automatic check(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("ERROR %0t: %s", $time, msg);
        end
    endtask

    task automatic add_row(input kind_e kind, input logic [15:0] addr, input logic [15:0] fill,
                           input logic [63:0] wdata, input logic [7:0] be, input logic [3:0] tid,
                           input bit exp_hit, input logic [63:0] exp_rdata);
        row_t r;
        r.kind = kind;
        r.addr = addr;
        r.fill = fill;
        r.wdata = wdata;
        r.be = be;
        r.tid = tid;
        r.exp_hit = exp_hit;
        r.exp_rdata = exp_rdata;
        rows.push_back(r);
    endtask

    task automatic check_response(input row_t r);
        check(core_rsp_tid_o == r.tid, $sformatf("tid %0d, expected %0d", core_rsp_tid_o, r.tid));
        check(core_rsp_hit_o == r.exp_hit,
              $sformatf("addr %h hit %0b, expected %0b", r.addr, core_rsp_hit_o, r.exp_hit));
        if (r.exp_hit && r.kind != K_STORE) begin
            check(core_rsp_rdata_o == r.exp_rdata,
                  $sformatf("addr %h data %h, expected %h", r.addr, core_rsp_rdata_o, r.exp_rdata));
        end
        // Miss request leaves in the same cycle as the response
        if (r.exp_hit) begin
            check(!miss_req_valid_o, $sformatf("miss request on hit to %h", r.addr));
        end else begin
            check(miss_req_valid_o && miss_req_addr_o == r.addr[15:3],
                  $sformatf("miss request %0b addr %h, expected line %h",
                            miss_req_valid_o, miss_req_addr_o, r.addr[15:3]));
        end
    endtask

    // Let every returned credit land, then stop the responder
    task automatic pause_credits();
        repeat (2) @(negedge clk);
        while (credit_due.size() > 0) @(negedge clk);
        repeat (2) @(negedge clk);
        hold_credits = 1'b1;
    endtask

    task automatic run_row(input row_t r);
        bit want_core;
        bit want_fill;
        bit core_acc;
        bit fill_acc;
        want_core = r.kind inside {K_LOAD, K_STORE, K_STARVED, K_BOTH};
        want_fill = r.kind inside {K_REFILL, K_BOTH};
        core_req_valid_i = want_core;
        core_req_op_i = (r.kind == K_STORE) ? cache_req_pkg::OP_STORE : cache_req_pkg::OP_LOAD;
        core_req_addr_i = r.addr;
        core_req_wdata_i = r.wdata;
        core_req_be_i = r.be;
        core_req_tid_i = r.tid;
        refill_valid_i = want_fill;
        refill_addr_i = r.fill[15:3];
        refill_data_i = r.wdata;
        if (r.kind == K_STARVED) begin
            repeat (8) begin
                #1;
                check(!core_req_ready_o, "core request accepted with no miss credits left");
                @(negedge clk);
            end
            hold_credits = 1'b0;
        end
        // Readies are settled between the falling and the rising edge
        while (want_core || want_fill) begin
            #1;
            core_acc = want_core && core_req_ready_o;
            fill_acc = want_fill && refill_ready_o;
            @(negedge clk);
            check(core_rsp_valid_o == core_acc,
                  $sformatf("response valid %0b, accepted %0b", core_rsp_valid_o, core_acc));
            if (fill_acc) begin
                refill_valid_i = 1'b0;
                want_fill = 1'b0;
            end
            if (core_acc) begin
                core_req_valid_i = 1'b0;
                want_core = 1'b0;
                check_response(r);
            end
        end
    endtask

    // Credit responder, one pulse per cycle at most
    initial begin
        void'($urandom(83));
        forever begin
            @(negedge clk);
            miss_credit_i = 1'b0;
            if (rst_n) begin
                if (miss_req_valid_o) begin
                    misses++;
                    credit_due.push_back(cycles + int'($urandom_range(4, 1)));
                end
                if (!hold_credits && credit_due.size() > 0 && credit_due[0] <= cycles) begin
                    void'(credit_due.pop_front());
                    miss_credit_i = 1'b1;
                    returned++;
                end
                check(misses <= returned + int'(MissCredits),
                      $sformatf("%0d miss requests with %0d credits returned", misses, returned));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        core_req_valid_i = 1'b0;
        core_req_op_i = cache_req_pkg::OP_LOAD;
        core_req_addr_i = '0;
        core_req_wdata_i = '0;
        core_req_be_i = '0;
        core_req_tid_i = '0;
        refill_valid_i = 1'b0;
        refill_addr_i = '0;
        refill_data_i = '0;
        miss_credit_i = 1'b0;
        add_row(K_LOAD,    16'h0040, 16'h0000, 64'h0, 8'h00, 4'd1, 1'b0, 64'h0);
        add_row(K_REFILL,  16'h0000, 16'h0040, 64'h1122_3344_5566_7788, 8'h00, 4'd0, 1'b0, 64'h0);
        add_row(K_LOAD,    16'h0040, 16'h0000, 64'h0, 8'h00, 4'd2, 1'b1, 64'h1122_3344_5566_7788);
        add_row(K_LOAD,    16'h0840, 16'h0000, 64'h0, 8'h00, 4'd3, 1'b0, 64'h0);
        add_row(K_STORE,   16'h0040, 16'h0000, 64'hAAAA_AAAA_AAAA_AAAA, 8'h0F, 4'd4, 1'b1, 64'h0);
        add_row(K_LOAD,    16'h0040, 16'h0000, 64'h0, 8'h00, 4'd5, 1'b1, 64'h1122_3344_AAAA_AAAA);
        add_row(K_STORE,   16'h0840, 16'h0000, 64'h5555_5555_5555_5555, 8'hFF, 4'd6, 1'b0, 64'h0);
        add_row(K_LOAD,    16'h0040, 16'h0000, 64'h0, 8'h00, 4'd7, 1'b1, 64'h1122_3344_AAAA_AAAA);
        add_row(K_REFILL,  16'h0000, 16'h0100, 64'h0F0E_0D0C_0B0A_0908, 8'h00, 4'd0, 1'b0, 64'h0);
        add_row(K_LOAD,    16'h0100, 16'h0000, 64'h0, 8'h00, 4'd8, 1'b1, 64'h0F0E_0D0C_0B0A_0908);
        add_row(K_PAUSE,   16'h0000, 16'h0000, 64'h0, 8'h00, 4'd0, 1'b0, 64'h0);
        add_row(K_LOAD,    16'h0200, 16'h0000, 64'h0, 8'h00, 4'd9, 1'b0, 64'h0);
        add_row(K_LOAD,    16'h0208, 16'h0000, 64'h0, 8'h00, 4'd10, 1'b0, 64'h0);
        add_row(K_STARVED, 16'h0210, 16'h0000, 64'h0, 8'h00, 4'd11, 1'b0, 64'h0);
        add_row(K_BOTH,    16'h0100, 16'h0290, 64'hCAFE_F00D_1234_5678, 8'h00, 4'd12, 1'b1,
                64'h0F0E_0D0C_0B0A_0908);
        add_row(K_LOAD,    16'h0290, 16'h0000, 64'h0, 8'h00, 4'd13, 1'b1, 64'hCAFE_F00D_1234_5678);
        add_row(K_BOTH,    16'h0040, 16'h0318, 64'h0123_4567_89AB_CDEF, 8'h00, 4'd14, 1'b1,
                64'h1122_3344_AAAA_AAAA);
        add_row(K_LOAD,    16'h0318, 16'h0000, 64'h0, 8'h00, 4'd15, 1'b1, 64'h0123_4567_89AB_CDEF);
        limit = rows.size() * CyclesPerRow;
        @(posedge rst_n);
        @(negedge clk);
        foreach (rows[i]) begin
            if (rows[i].kind == K_PAUSE) begin
                pause_credits();
            end else begin
                run_row(rows[i]);
            end
        end
        repeat (2) @(negedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/tb_clock_gen.sv ====
////////////////////
// Testbench clock and reset source
////////////////////
module tb_clock_gen #(
    parameter int unsigned ResetCycles = 2
) (
    output logic clk_o,
    output logic rst_no
);
    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        rst_no = 1'b0;
        repeat (ResetCycles) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

// ==== src/cache_ctrl_top.sv ====
////////////////////
// Cache controller top level
// Arbiter, directory and data arrays, resolver
////////////////////
module cache_ctrl_top #(
    parameter int unsigned MissCredits = 2
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,

    input  logic                                core_req_valid_i,
    output logic                                core_req_ready_o,
    input  cache_req_pkg::op_e                  core_req_op_i,
    input  logic [cache_cfg_pkg::AddrWidth-1:0] core_req_addr_i,
    input  logic [63:0]                         core_req_wdata_i,
    input  logic [7:0]                          core_req_be_i,
    input  logic [cache_cfg_pkg::TidWidth-1:0]  core_req_tid_i,

    output logic                                core_rsp_valid_o,
    output logic [63:0]                         core_rsp_rdata_o,
    output logic [cache_cfg_pkg::TidWidth-1:0]  core_rsp_tid_o,
    output logic                                core_rsp_hit_o,

    input  logic                                refill_valid_i,
    output logic                                refill_ready_o,
    input  logic [cache_cfg_pkg::TagWidth+cache_cfg_pkg::SetWidth-1:0] refill_addr_i,
    input  logic [63:0]                         refill_data_i,

    output logic                                miss_req_valid_o,
    output logic [cache_cfg_pkg::TagWidth+cache_cfg_pkg::SetWidth-1:0] miss_req_addr_o,

    input  logic                                miss_credit_i
);

    cache_req_pkg::core_req_t  core_req;
    cache_req_pkg::core_rsp_t  core_rsp;
    cache_req_pkg::refill_t    refill;

    logic                      s0_valid;
    logic                      s0_is_refill;
    cache_req_pkg::core_req_t  s0_req;
    cache_req_pkg::refill_t    s0_refill;
    logic                      s1_miss;

    assign core_req = '{op: core_req_op_i, addr: core_req_addr_i, wdata: core_req_wdata_i,
                        be: core_req_be_i, tid: core_req_tid_i};
    assign refill   = '{tag: refill_addr_i[cache_cfg_pkg::SetWidth +: cache_cfg_pkg::TagWidth],
                        set: refill_addr_i[cache_cfg_pkg::SetWidth-1:0],
                        data: refill_data_i};

    assign core_rsp_rdata_o = core_rsp.rdata;
    assign core_rsp_tid_o   = core_rsp.tid;
    assign core_rsp_hit_o   = core_rsp.hit;

    array_if #(.entry_t(cache_req_pkg::dir_entry_t)) dir_bus ();
    array_if #(.entry_t(cache_req_pkg::word_t))      data_bus ();

    req_arbiter #(
        .MissCredits (MissCredits)
    ) arbiter (
        .clk_i, .rst_ni,
        .core_req_valid_i, .core_req_ready_o, .core_req_i (core_req),
        .refill_valid_i, .refill_ready_o, .refill_i (refill),
        .miss_credit_i, .s1_miss_i (s1_miss),
        .s0_valid_o (s0_valid), .s0_is_refill_o (s0_is_refill),
        .s0_req_o (s0_req), .s0_refill_o (s0_refill),
        .dir_o (dir_bus.lookup), .data_o (data_bus.lookup)
    );

    cache_set_array #(.entry_t(cache_req_pkg::dir_entry_t)) dir_array (
        .clk_i, .rst_ni, .arr_o (dir_bus.array)
    );

    cache_set_array #(.entry_t(cache_req_pkg::word_t)) data_array (
        .clk_i, .rst_ni, .arr_o (data_bus.array)
    );

    hit_resolve resolver (
        .clk_i, .rst_ni,
        .s0_valid_i (s0_valid), .s0_is_refill_i (s0_is_refill),
        .s0_req_i (s0_req), .s0_refill_i (s0_refill),
        .s1_miss_o (s1_miss),
        .dir_o (dir_bus.update), .data_o (data_bus.update),
        .core_rsp_valid_o, .core_rsp_o (core_rsp),
        .miss_req_valid_o, .miss_req_addr_o
    );

endmodule

// ==== src/hit_resolve.sv ====
////////////////////
// Stage-1 tag compare and store merge
// Refill write, core response, miss request
////////////////////
module hit_resolve (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    input  logic                      s0_valid_i,
    input  logic                      s0_is_refill_i,
    input  cache_req_pkg::core_req_t  s0_req_i,
    input  cache_req_pkg::refill_t    s0_refill_i,

    output logic                      s1_miss_o,

    array_if.update                   dir_o,
    array_if.update                   data_o,

    output logic                      core_rsp_valid_o,
    output cache_req_pkg::core_rsp_t  core_rsp_o,

    output logic                      miss_req_valid_o,
    output logic [cache_cfg_pkg::TagWidth+cache_cfg_pkg::SetWidth-1:0] miss_req_addr_o
);

    logic                                s1_core;
    logic                                s1_refill;
    logic                                s1_store;
    logic                                hit;
    logic [cache_cfg_pkg::TagWidth-1:0]  req_tag;
    logic [cache_cfg_pkg::SetWidth-1:0]  req_set;
    cache_req_pkg::word_t                merged;

    // The stage-0 register feeds this stage directly
    assign s1_core   = s0_valid_i & ~s0_is_refill_i;
    assign s1_refill = s0_valid_i & s0_is_refill_i;
    assign s1_store  = s0_req_i.op == cache_req_pkg::OP_STORE;

    assign req_tag = s0_req_i.addr[cache_cfg_pkg::AddrWidth-1 -: cache_cfg_pkg::TagWidth];
    assign req_set = s0_req_i.addr[cache_cfg_pkg::OffsetWidth +: cache_cfg_pkg::SetWidth];

    assign hit = dir_o.rdata.valid && (dir_o.rdata.tag == req_tag);

    // Byte-wise merge of store data into the stored word
    always_comb begin
        merged = data_o.rdata;
        for (int b = 0; b < int'(cache_cfg_pkg::WordBytes); b++) begin
            if (s0_req_i.be[b]) begin
                merged[8*b +: 8] = s0_req_i.wdata[8*b +: 8];
            end
        end
    end

    // Directory is written by refills only
    assign dir_o.wr_en       = s1_refill;
    assign dir_o.wr_set      = s0_refill_i.set;
    assign dir_o.wdata.valid = 1'b1;
    assign dir_o.wdata.tag   = s0_refill_i.tag;

    // Data written by refills and by store hits
    assign data_o.wr_en  = s1_refill | (s1_core & s1_store & hit);
    assign data_o.wr_set = s1_refill ? s0_refill_i.set : req_set;
    assign data_o.wdata  = s1_refill ? s0_refill_i.data : merged;

    assign core_rsp_valid_o = s1_core;
    assign core_rsp_o.rdata = data_o.rdata;
    assign core_rsp_o.tid   = s0_req_i.tid;
    assign core_rsp_o.hit   = hit;

    // A load or store miss goes out at once and the core retries later
    assign s1_miss_o        = s1_core & ~hit;
    assign miss_req_valid_o = s1_miss_o;
    assign miss_req_addr_o  = {req_tag, req_set};

    // Lookup issued at the refill's write edge sees the new entry
    a_refill_seen: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (s1_core && $past(s1_refill) && (req_set == $past(s0_refill_i.set)))
            |-> (dir_o.rdata == $past(dir_o.wdata))
    ) else $error("lookup right after a refill missed the new directory entry");

endmodule

// ==== src/req_arbiter.sv ====
////////////////////
// Stage-0 arbiter between core and refill
// Miss credit counter and array lookups
////////////////////
module req_arbiter #(
    parameter int unsigned MissCredits = 2
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    input  logic                      core_req_valid_i,
    output logic                      core_req_ready_o,
    input  cache_req_pkg::core_req_t  core_req_i,

    input  logic                      refill_valid_i,
    output logic                      refill_ready_o,
    input  cache_req_pkg::refill_t    refill_i,

    input  logic                      miss_credit_i,
    input  logic                      s1_miss_i,

    output logic                      s0_valid_o,
    output logic                      s0_is_refill_o,
    output cache_req_pkg::core_req_t  s0_req_o,
    output cache_req_pkg::refill_t    s0_refill_o,

    array_if.lookup                   dir_o,
    array_if.lookup                   data_o
);

    localparam int unsigned CntWidth = $clog2(MissCredits + 1);

    logic                 init_q;
    logic                 last_refill_q;
    logic [CntWidth-1:0]  credit_q;

    logic s1_core;
    logic credit_ok;
    logic core_elig;
    logic core_gnt;
    logic refill_gnt;
    logic core_acc;
    logic refill_acc;

    // A core item in stage 1 may still miss, so keep one credit back for it
    assign s1_core   = s0_valid_o & ~s0_is_refill_o;
    assign credit_ok = int'(credit_q) > int'(s1_core);
    assign core_elig = core_req_valid_i & credit_ok;

    // Round robin where the source not served last time wins a tie
    always_comb begin
        core_gnt   = 1'b0;
        refill_gnt = 1'b0;
        if (core_elig && refill_valid_i) begin
            refill_gnt = ~last_refill_q;
            core_gnt   = last_refill_q;
        end else begin
            core_gnt   = core_elig;
            refill_gnt = refill_valid_i;
        end
    end

    assign core_req_ready_o = init_q & core_gnt;
    assign refill_ready_o   = init_q & refill_gnt;

    assign core_acc   = core_req_valid_i & core_req_ready_o;
    assign refill_acc = refill_valid_i & refill_ready_o;

    // Lookups only for core requests; refills just write
    assign dir_o.rd_en   = core_acc;
    assign dir_o.rd_set  = core_req_i.addr[cache_cfg_pkg::OffsetWidth +: cache_cfg_pkg::SetWidth];
    assign data_o.rd_en  = core_acc;
    assign data_o.rd_set = core_req_i.addr[cache_cfg_pkg::OffsetWidth +: cache_cfg_pkg::SetWidth];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_q         <= 1'b0;
            last_refill_q  <= 1'b0;
            s0_valid_o     <= 1'b0;
            s0_is_refill_o <= 1'b0;
        end else begin
            init_q         <= 1'b1;
            s0_valid_o     <= core_acc | refill_acc;
            s0_is_refill_o <= refill_acc;
            if (core_acc || refill_acc) begin
                last_refill_q <= refill_acc;
            end
        end
    end

    // Spent on each miss leaving stage 1, returned on each credit pulse
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            credit_q <= CntWidth'(MissCredits);
        end else begin
            case ({s1_miss_i, miss_credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (core_acc) begin
            s0_req_o <= core_req_i;
        end
        if (refill_acc) begin
            s0_refill_o <= refill_i;
        end
    end

    a_credit_left: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        s1_miss_i |-> (credit_q != '0)
    ) else $error("miss request sent with no credit left");

    a_credit_bound: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        int'(credit_q) <= int'(MissCredits)
    ) else $error("miss credit counter above its limit");

endmodule

// ==== src/cache_set_array.sv ====
////////////////////
// Set-indexed storage array
// One read port, one write port, write-first bypass
////////////////////
module cache_set_array #(
    parameter type entry_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    array_if.array   arr_o
);

    entry_t mem_q [cache_cfg_pkg::Sets];

    // All entries start cleared, so directory lines come up invalid
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < int'(cache_cfg_pkg::Sets); i++) begin
                mem_q[i] <= '0;
            end
        end else if (arr_o.wr_en) begin
            mem_q[arr_o.wr_set] <= arr_o.wdata;
        end
    end

    // Registered read; a write to the same set at this edge wins
    always_ff @(posedge clk_i) begin
        if (arr_o.rd_en) begin
            if (arr_o.wr_en && (arr_o.wr_set == arr_o.rd_set)) begin
                arr_o.rdata <= arr_o.wdata;
            end else begin
                arr_o.rdata <= mem_q[arr_o.rd_set];
            end
        end
    end

    a_sets_in_range: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (arr_o.rd_en |-> (int'(arr_o.rd_set) < int'(cache_cfg_pkg::Sets))) and
        (arr_o.wr_en |-> (int'(arr_o.wr_set) < int'(cache_cfg_pkg::Sets)))
    ) else $error("set array index out of range");

endmodule

// ==== src/array_if.sv ====
////////////////////
// Read and write port bundle of one set array
////////////////////
interface array_if #(
    parameter type entry_t = logic
) ();

    // Read port, data returns one cycle later
    logic                                rd_en;
    logic [cache_cfg_pkg::SetWidth-1:0]  rd_set;
    entry_t                              rdata;

    // Write port
    logic                                wr_en;
    logic [cache_cfg_pkg::SetWidth-1:0]  wr_set;
    entry_t                              wdata;

    modport lookup (output rd_en, output rd_set);

    modport update (input rdata, output wr_en, output wr_set, output wdata);

    modport array (
        input  rd_en, input rd_set, output rdata,
        input  wr_en, input wr_set, input wdata
    );

endinterface

// ==== src/cache_req_pkg.sv ====
////////////////////
// Core request and response types
// Refill and directory entry types
////////////////////
package cache_req_pkg;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } op_e;

    typedef logic [63:0] word_t;

    typedef struct packed {
        op_e                                  op;
        logic [cache_cfg_pkg::AddrWidth-1:0]  addr;
        word_t                                wdata;
        logic [cache_cfg_pkg::WordBytes-1:0]  be;
        logic [cache_cfg_pkg::TidWidth-1:0]   tid;
    } core_req_t;

    typedef struct packed {
        word_t                                rdata;
        logic [cache_cfg_pkg::TidWidth-1:0]   tid;
        logic                                 hit;
    } core_rsp_t;

    // Line address split into tag and set, plus the line data
    typedef struct packed {
        logic [cache_cfg_pkg::TagWidth-1:0]   tag;
        logic [cache_cfg_pkg::SetWidth-1:0]   set;
        word_t                                data;
    } refill_t;

    typedef struct packed {
        logic                                 valid;
        logic [cache_cfg_pkg::TagWidth-1:0]   tag;
    } dir_entry_t;

endpackage

// ==== src/cache_cfg_pkg.sv ====
////////////////////
// Cache geometry constants
// Address split widths for tag, set and byte offset
////////////////////
package cache_cfg_pkg;

    // Byte address
    localparam int unsigned AddrWidth = 16;

    // One 64-bit word per line
    localparam int unsigned WordBytes = 8;
    localparam int unsigned OffsetWidth = 3;

    // Direct-mapped sets
    localparam int unsigned Sets = 16;
    localparam int unsigned SetWidth = 4;

    // Remaining upper address bits
    localparam int unsigned TagWidth = AddrWidth - SetWidth - OffsetWidth;

    // Core transaction id
    localparam int unsigned TidWidth = 4;

endpackage
